//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       ?= tb_iigs_glue
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Test OK" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- files.f
iigs_switch_pkg.sv
iigs_bus_pkg.sv
io_decode.sv
softswitch_regs.sv
memory_map.sv
irq_ctrl.sv
iigs_glue.sv
tb_iigs_glue.sv

//--- iigs_bus_pkg.sv
package iigs_bus_pkg;

	import iigs_switch_pkg::*;

	localparam logic [7:0] BANK_00 = 8'h00;
	localparam logic [7:0] BANK_01 = 8'h01;
	localparam logic [7:0] BANK_E0 = 8'hE0;
	localparam logic [7:0] BANK_E1 = 8'hE1;

	localparam logic [7:0]  IO_PAGE  = 8'hC0;
	localparam logic [15:0] LC_BASE  = 16'hD000; // language card window
	localparam logic [15:0] LC_TOP   = 16'hDFFF;
	localparam logic [15:0] LC_SHIFT = 16'h1000; // bank 2 sits one 4k block lower

	// one cpu access
	typedef struct packed {
		logic [7:0]  bank;
		logic [15:0] addr;
		logic        rw;    // 1 read, 0 write
		logic [7:0]  wdata;
	} bus_req_t;

	typedef struct packed {
		bus_req_t req;
		logic     is_io;
		io_reg_e  io_reg;
	} dec_req_t;

	typedef struct packed {
		logic [7:0]  bank;
		logic [15:0] addr;
	} mapped_addr_t;

endpackage

//--- iigs_glue.sv
`timescale 1ns/1ns

module iigs_glue
	import iigs_bus_pkg::*;
	import iigs_switch_pkg::*;
#(
	parameter bit IO_BANK_MASK_EN = 1'b1
) (
	input  logic         clk_sys,
	input  logic         cpu_vda,
	input  logic         req_valid,
	input  bus_req_t     req,
	input  logic         vblank,
	input  logic         scanline_irq,
	input  logic         vbl_irq,
	input  logic         onesecond_irq,
	input  logic         qtrsecond_irq,
	output logic         rd_valid,
	output logic [7:0]   rd_data,
	output logic         mem_valid,
	output mapped_addr_t mem_addr,
	output video_state_t video,
	output logic         irq
);

	logic        dec_valid;
	dec_req_t    dec;
	mem_switch_t mem_sw;
	irq_wr_t     irq_wr;
	irq_en_t     irq_en;
	logic [7:0]  vgcint;
	logic [7:0]  intflag;

	// stage 1
	io_decode #(
		.IO_BANK_MASK_EN(IO_BANK_MASK_EN)
	) u_io_decode (
		.clk_sys  (clk_sys),
		.cpu_vda  (cpu_vda),
		.req_valid(req_valid),
		.req      (req),
		.dec_valid(dec_valid),
		.dec      (dec)
	);

	// stage 2, io side
	softswitch_regs u_softswitch_regs (
		.clk_sys  (clk_sys),
		.cpu_vda  (cpu_vda),
		.dec_valid(dec_valid),
		.dec      (dec),
		.vblank   (vblank),
		.irq_en   (irq_en),
		.vgcint   (vgcint),
		.intflag  (intflag),
		.mem_sw   (mem_sw),
		.video    (video),
		.irq_wr   (irq_wr),
		.rd_valid (rd_valid),
		.rd_data  (rd_data)
	);

	// stage 2, memory side
	memory_map u_memory_map (
		.clk_sys  (clk_sys),
		.cpu_vda  (cpu_vda),
		.dec_valid(dec_valid),
		.dec      (dec),
		.mem_sw   (mem_sw),
		.mem_valid(mem_valid),
		.mem_addr (mem_addr)
	);

	irq_ctrl u_irq_ctrl (
		.clk_sys      (clk_sys),
		.cpu_vda      (cpu_vda),
		.scanline_irq (scanline_irq),
		.vbl_irq      (vbl_irq),
		.onesecond_irq(onesecond_irq),
		.qtrsecond_irq(qtrsecond_irq),
		.irq_wr       (irq_wr),
		.irq_en       (irq_en),
		.vgcint       (vgcint),
		.intflag      (intflag),
		.irq          (irq)
	);

endmodule

//--- iigs_switch_pkg.sv
package iigs_switch_pkg;

	// C0xx offsets, low byte of the I/O address
	typedef enum logic [7:0] {
		STORE80_OFF  = 8'h00, STORE80_ON  = 8'h01,
		RAMRD_OFF    = 8'h02, RAMRD_ON    = 8'h03,
		RAMWRT_OFF   = 8'h04, RAMWRT_ON   = 8'h05,
		INTCXROM_OFF = 8'h06, INTCXROM_ON = 8'h07,
		ALTZP_OFF    = 8'h08, ALTZP_ON    = 8'h09,
		SLOTC3_OFF   = 8'h0A, SLOTC3_ON   = 8'h0B,
		COL80_OFF    = 8'h0C, COL80_ON    = 8'h0D,
		ALTCHAR_OFF  = 8'h0E, ALTCHAR_ON  = 8'h0F,
		RD_LCBNK2    = 8'h11, RD_RDROM    = 8'h12, RD_RAMRD   = 8'h13,
		RD_RAMWRT    = 8'h14, RD_INTCXROM = 8'h15, RD_ALTZP   = 8'h16,
		RD_SLOTC3    = 8'h17, RD_80STORE  = 8'h18, RD_VBL     = 8'h19,
		RD_TEXT      = 8'h1A, RD_MIXED    = 8'h1B, RD_PAGE2   = 8'h1C,
		RD_HIRES     = 8'h1D, RD_ALTCHAR  = 8'h1E, RD_80COL   = 8'h1F,
		TEXTCOLOR    = 8'h22, VGCINT      = 8'h23, NEWVIDEO   = 8'h29,
		SLTROMSEL    = 8'h2D, VGCINT_CLR  = 8'h32, CLOCKCTL   = 8'h34,
		SHADOW       = 8'h35, CYAREG      = 8'h36, INTEN      = 8'h41,
		INTFLAG      = 8'h46, CLRVBL      = 8'h47,
		TXTCLR       = 8'h50, TXTSET      = 8'h51, MIXCLR     = 8'h52,
		MIXSET       = 8'h53, LOWSCR      = 8'h54, HISCR      = 8'h55,
		LORES        = 8'h56, HIRES       = 8'h57,
		STATEREG     = 8'h68,
		LC_BASE_OFF  = 8'h80 // c080..c08f language card
	} io_reg_e;

	typedef struct packed {
		logic store80;
		logic ramrd;
		logic ramwrt;
		logic altzp;
		logic page2;
		logic hires;
		logic lcram2;
		logic rdrom;
	} mem_switch_t;

	typedef struct packed {
		logic       textg;
		logic       mixg;
		logic       page2;
		logic       hires;
		logic [7:0] newvideo;
		logic [7:0] textcolor;
		logic [3:0] bordercolor;
	} video_state_t;

	typedef struct packed {
		logic scan_en; // vgcint bit 1
		logic sec_en;  // vgcint bit 2
		logic vbl_en;  // inten bit 3
		logic qtr_en;  // inten bit 4
	} irq_en_t;

	// interrupt register write, one cycle strobe
	typedef struct packed {
		logic       strobe;
		io_reg_e    off;
		logic [7:0] data;
	} irq_wr_t;

	localparam logic [7:0] SHADOW_RST    = 8'h08;
	localparam logic [7:0] NEWVIDEO_RST  = 8'h41;
	localparam logic [7:0] CYAREG_RST    = 8'h80;
	localparam logic [7:0] TEXTCOLOR_RST = 8'hF2;

endpackage

//--- io_decode.sv
`timescale 1ns/1ns

module io_decode
	import iigs_bus_pkg::*;
	import iigs_switch_pkg::*;
#(
	parameter bit IO_BANK_MASK_EN = 1'b1
) (
	input  logic     clk_sys,
	input  logic     cpu_vda,
	input  logic     req_valid,
	input  bus_req_t req,
	output logic     dec_valid,
	output dec_req_t dec
);

	logic main_bank;
	logic shadow_bank;
	logic bank_ok;
	logic is_io;

	assign main_bank   = (req.bank == BANK_00) || (req.bank == BANK_E0);
	assign shadow_bank = (req.bank == BANK_01) || (req.bank == BANK_E1);

	// 01/e1 only see the io page when enabled
	assign bank_ok = main_bank || (IO_BANK_MASK_EN && shadow_bank);
	assign is_io   = bank_ok && (req.addr[15:8] == IO_PAGE);

	always_ff @(posedge clk_sys or posedge cpu_vda) begin
		if (cpu_vda) begin
			dec_valid <= 1'b0;
		end else begin
			dec_valid <= req_valid;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (req_valid) begin
			dec.req    <= req;
			dec.is_io  <= is_io;
			dec.io_reg <= io_reg_e'(req.addr[7:0]); // offset within c0xx
		end
	end

endmodule

//--- irq_ctrl.sv
`timescale 1ns/1ns

module irq_ctrl
	import iigs_switch_pkg::*;
(
	input  logic       clk_sys,
	input  logic       cpu_vda,
	input  logic       scanline_irq,
	input  logic       vbl_irq,
	input  logic       onesecond_irq,
	input  logic       qtrsecond_irq,
	input  irq_wr_t    irq_wr,
	output irq_en_t    irq_en,
	output logic [7:0] vgcint,
	output logic [7:0] intflag,
	output logic       irq
);

	logic scan_st; // vgcint bit 5
	logic sec_st;  // vgcint bit 6
	logic vgc_any; // vgcint bit 7
	logic vbl_fl;
	logic qtr_fl;

	assign vgcint  = {vgc_any, sec_st, scan_st, 5'b00000};
	assign intflag = {3'b000, qtr_fl, vbl_fl, 3'b000};

	always_ff @(posedge clk_sys or posedge cpu_vda) begin
		if (cpu_vda) begin
			irq_en  <= '0;
			scan_st <= 1'b0;
			sec_st  <= 1'b0;
			vgc_any <= 1'b0;
			vbl_fl  <= 1'b0;
			qtr_fl  <= 1'b0;
			irq     <= 1'b0;
		end else begin
			if (irq_wr.strobe) begin
				case (irq_wr.off)
					VGCINT: begin
						irq_en.sec_en  <= irq_wr.data[2];
						irq_en.scan_en <= irq_wr.data[1];
					end
					INTEN: begin // mouse enables in bits 2:0 not modelled
						irq_en.qtr_en <= irq_wr.data[4];
						irq_en.vbl_en <= irq_wr.data[3];
					end
					VGCINT_CLR: begin
						if (!irq_wr.data[5])
							scan_st <= 1'b0;
						if (!irq_wr.data[6])
							sec_st <= 1'b0;
						// summary bit drops once neither source is left pending
						if ((!scan_st || !irq_wr.data[5]) && (!sec_st || !irq_wr.data[6]))
							vgc_any <= 1'b0;
					end
					CLRVBL: begin
						vbl_fl <= 1'b0;
						qtr_fl <= 1'b0;
					end
					default: ;
				endcase
			end
			// new events win over a clear on the same edge
			if (scanline_irq) begin
				scan_st <= 1'b1; // status set even when masked
				if (irq_en.scan_en)
					vgc_any <= 1'b1;
			end
			if (onesecond_irq && irq_en.sec_en) begin
				sec_st  <= 1'b1;
				vgc_any <= 1'b1;
			end
			if (vbl_irq && irq_en.vbl_en)
				vbl_fl <= 1'b1;
			if (qtrsecond_irq && irq_en.qtr_en)
				qtr_fl <= 1'b1;
			irq <= (sec_st && irq_en.sec_en) || (scan_st && irq_en.scan_en)
				|| (vbl_fl && irq_en.vbl_en) || (qtr_fl && irq_en.qtr_en);
		end
	end

endmodule

//--- memory_map.sv
`timescale 1ns/1ns

module memory_map
	import iigs_bus_pkg::*;
	import iigs_switch_pkg::*;
(
	input  logic         clk_sys,
	input  logic         cpu_vda,
	input  logic         dec_valid,
	input  dec_req_t     dec,
	input  mem_switch_t  mem_sw,
	output logic         mem_valid,
	output mapped_addr_t mem_addr
);

	logic [7:0] page;
	logic main_bank;
	logic rw_aux;
	logic aux_sel;
	logic lc_remap;
	logic mem_acc;
	mapped_addr_t mapped;

	assign page      = dec.req.addr[15:8];
	assign main_bank = (dec.req.bank == BANK_00) || (dec.req.bank == BANK_E0);
	assign rw_aux    = dec.req.rw ? mem_sw.ramrd : mem_sw.ramwrt;
	assign mem_acc   = dec_valid && !dec.is_io;

	always_comb begin
		if (page[7:1] == 7'h00 || page[7:6] == 2'b11) begin
			aux_sel = mem_sw.altzp; // zp, stack and lc space
		end else if (page[7:2] == 6'b000001 && mem_sw.store80) begin
			aux_sel = mem_sw.page2; // text page 1
		end else if (page[7:5] == 3'b001 && mem_sw.store80 && mem_sw.hires) begin
			aux_sel = mem_sw.page2; // hires page 1
		end else begin
			aux_sel = rw_aux;
		end
	end

	assign lc_remap = main_bank && (dec.req.addr >= LC_BASE) && (dec.req.addr <= LC_TOP)
		&& mem_sw.lcram2 && !mem_sw.rdrom;

	always_comb begin
		mapped.addr = lc_remap ? dec.req.addr - LC_SHIFT : dec.req.addr;
		mapped.bank = (main_bank && aux_sel) ? dec.req.bank + 8'h01 : dec.req.bank;
	end

	always_ff @(posedge clk_sys or posedge cpu_vda) begin
		if (cpu_vda) begin
			mem_valid <= 1'b0;
		end else begin
			mem_valid <= mem_acc;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (mem_acc) begin
			mem_addr <= mapped;
		end
	end

	// the c0xx page of banks 00 and e0 never reaches the memory side
	assert property (@(posedge clk_sys) disable iff (cpu_vda)
		mem_valid |-> $past(!(main_bank && page == IO_PAGE)));

endmodule

//--- softswitch_regs.sv
`timescale 1ns/1ns

module softswitch_regs
	import iigs_bus_pkg::*;
	import iigs_switch_pkg::*;
(
	input  logic         clk_sys,
	input  logic         cpu_vda,
	input  logic         dec_valid,
	input  dec_req_t     dec,
	input  logic         vblank,
	input  irq_en_t      irq_en,
	input  logic [7:0]   vgcint,
	input  logic [7:0]   intflag,
	output mem_switch_t  mem_sw,
	output video_state_t video,
	output irq_wr_t      irq_wr,
	output logic         rd_valid,
	output logic [7:0]   rd_data
);

	logic [7:0] reg_off;
	logic io_acc;
	logic io_rd;
	logic io_wr;
	logic lc_acc;
	logic intcxrom;
	logic slotc3rom;
	logic col80;
	logic altchar;
	logic lc_we;
	logic prewrite; // first odd read seen
	logic textg;
	logic mixg;
	logic [7:0] newvideo;
	logic [7:0] textcolor;
	logic [3:0] bordercolor;
	logic [7:0] sltromsel;
	logic [7:0] shadow;
	logic [7:0] cyareg;
	logic [7:0] rd_next;

	function automatic logic [7:0] flag_byte(input logic f);
		return {f, 7'h00};
	endfunction

	assign reg_off = dec.io_reg;
	assign io_acc  = dec_valid && dec.is_io;
	assign io_rd   = io_acc && dec.req.rw;
	assign io_wr   = io_acc && !dec.req.rw;
	assign lc_acc  = io_acc && ((reg_off & 8'hF0) == LC_BASE_OFF);

	// irq_ctrl updates on the same edge as the switches
	always_comb begin
		irq_wr.strobe = io_wr && (dec.io_reg inside {VGCINT, VGCINT_CLR, INTEN, CLRVBL});
		irq_wr.off    = dec.io_reg;
		irq_wr.data   = dec.req.wdata;
	end

	always_ff @(posedge clk_sys or posedge cpu_vda) begin
		if (cpu_vda) begin
			mem_sw      <= '0;
			intcxrom    <= 1'b0;
			slotc3rom   <= 1'b0;
			col80       <= 1'b0;
			altchar     <= 1'b0;
			lc_we       <= 1'b0;
			prewrite    <= 1'b0;
			textg       <= 1'b0;
			mixg        <= 1'b0;
			newvideo    <= NEWVIDEO_RST;
			textcolor   <= TEXTCOLOR_RST;
			bordercolor <= 4'h0;
			sltromsel   <= 8'h00;
			shadow      <= SHADOW_RST;
			cyareg      <= CYAREG_RST;
		end else if (io_acc) begin
			if (io_wr) begin
				case (dec.io_reg)
					STORE80_OFF, STORE80_ON:   mem_sw.store80 <= reg_off[0];
					INTCXROM_OFF, INTCXROM_ON: intcxrom <= reg_off[0];
					ALTZP_OFF, ALTZP_ON:       mem_sw.altzp <= reg_off[0];
					SLOTC3_OFF, SLOTC3_ON:     slotc3rom <= reg_off[0];
					COL80_OFF, COL80_ON:       col80 <= reg_off[0];
					ALTCHAR_OFF, ALTCHAR_ON:   altchar <= reg_off[0];
					TEXTCOLOR: textcolor <= dec.req.wdata;
					NEWVIDEO:  newvideo <= dec.req.wdata;
					SLTROMSEL: sltromsel <= dec.req.wdata;
					CLOCKCTL:  bordercolor <= dec.req.wdata[3:0]; // low nibble only
					SHADOW:    shadow <= dec.req.wdata;
					CYAREG:    cyareg <= dec.req.wdata;
					STATEREG: begin
						{mem_sw.altzp, mem_sw.page2, mem_sw.ramrd, mem_sw.ramwrt,
							mem_sw.rdrom, mem_sw.lcram2, lc_we, intcxrom} <= dec.req.wdata;
					end
					default: ;
				endcase
			end
			// these toggle on read or write
			case (dec.io_reg)
				RAMRD_OFF, RAMRD_ON:   mem_sw.ramrd <= reg_off[0];
				RAMWRT_OFF, RAMWRT_ON: mem_sw.ramwrt <= reg_off[0];
				TXTCLR, TXTSET:        textg <= reg_off[0];
				MIXCLR, MIXSET:        mixg <= reg_off[0];
				LOWSCR, HISCR:         mem_sw.page2 <= reg_off[0];
				LORES, HIRES:          mem_sw.hires <= reg_off[0];
				default: ;
			endcase
			if (lc_acc) begin
				mem_sw.lcram2 <= ~reg_off[3];
				mem_sw.rdrom  <= reg_off[0] ^ reg_off[1];
				if (io_rd && reg_off[0]) begin
					lc_we    <= prewrite; // second odd read enables writes
					prewrite <= 1'b1;
				end else begin
					lc_we    <= 1'b0;
					prewrite <= 1'b0;
				end
			end
		end
	end

	always_comb begin
		rd_next = 8'h00;
		case (dec.io_reg)
			RD_LCBNK2:   rd_next = flag_byte(mem_sw.lcram2);
			RD_RDROM:    rd_next = flag_byte(mem_sw.rdrom);
			RD_RAMRD:    rd_next = flag_byte(mem_sw.ramrd);
			RD_RAMWRT:   rd_next = flag_byte(mem_sw.ramwrt);
			RD_INTCXROM: rd_next = flag_byte(intcxrom);
			RD_ALTZP:    rd_next = flag_byte(mem_sw.altzp);
			RD_SLOTC3:   rd_next = flag_byte(slotc3rom);
			RD_80STORE:  rd_next = flag_byte(mem_sw.store80);
			RD_VBL:      rd_next = flag_byte(!vblank);
			RD_TEXT:     rd_next = flag_byte(textg);
			RD_MIXED:    rd_next = flag_byte(mixg);
			RD_PAGE2:    rd_next = flag_byte(mem_sw.page2);
			RD_HIRES:    rd_next = flag_byte(!mem_sw.hires);
			RD_ALTCHAR:  rd_next = flag_byte(altchar);
			RD_80COL:    rd_next = flag_byte(col80);
			TEXTCOLOR:   rd_next = textcolor;
			VGCINT:      rd_next = vgcint | {5'b0, irq_en.sec_en, irq_en.scan_en, 1'b0};
			NEWVIDEO:    rd_next = newvideo;
			SLTROMSEL:   rd_next = sltromsel;
			CLOCKCTL:    rd_next = {4'h0, bordercolor};
			SHADOW:      rd_next = shadow;
			CYAREG:      rd_next = cyareg;
			INTEN:       rd_next = {3'b000, irq_en.qtr_en, irq_en.vbl_en, 3'b000};
			INTFLAG:     rd_next = intflag;
			// bit 1 carries lc_we
			STATEREG: rd_next = {mem_sw.altzp, mem_sw.page2, mem_sw.ramrd, mem_sw.ramwrt,
				mem_sw.rdrom, mem_sw.lcram2, lc_we, intcxrom};
			default: ;
		endcase
	end

	always_ff @(posedge clk_sys or posedge cpu_vda) begin
		if (cpu_vda) begin
			rd_valid <= 1'b0;
		end else begin
			rd_valid <= io_rd;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (io_rd) begin
			rd_data <= rd_next; // sampled before this access takes effect
		end
	end

	always_comb begin
		video.textg       = textg;
		video.mixg        = mixg;
		video.page2       = mem_sw.page2;
		video.hires       = mem_sw.hires;
		video.newvideo    = newvideo;
		video.textcolor   = textcolor;
		video.bordercolor = bordercolor;
	end

	// enables are merged into the low bits of the vgcint byte on readback
	assert property (@(posedge clk_sys) disable iff (cpu_vda)
		vgcint[4:0] == 5'b00000);

endmodule

//--- tb_iigs_glue.sv
`timescale 1ns/1ns

module tb_iigs_glue
	import iigs_bus_pkg::*;
	import iigs_switch_pkg::*;
();

	localparam bit IO_MASK = 1'b1; // io also decodes in banks 01 and e1
	localparam int WATCHDOG_CYCLES = 20000;
	localparam logic [7:0] MEGA_REGS [7] = '{TEXTCOLOR, NEWVIDEO, SLTROMSEL, CLOCKCTL,
		SHADOW, CYAREG, STATEREG};

	logic         clk_sys;
	logic         cpu_vda;
	logic         req_valid;
	bus_req_t     req;
	logic         vblank;
	logic         scanline_irq;
	logic         vbl_irq;
	logic         onesecond_irq;
	logic         qtrsecond_irq;
	logic         rd_valid;
	logic [7:0]   rd_data;
	logic         mem_valid;
	mapped_addr_t mem_addr;
	video_state_t video;
	logic         irq;

	int seed = 20;
	int n_checks = 0;
	int n_errors = 0;
	int c_mark = 0;
	int e_mark = 0;

	// reference model state
	mem_switch_t m_sw;
	logic m_intcxrom;
	logic m_slotc3;
	logic m_col80;
	logic m_altchar;
	logic m_lc_we;
	logic m_prewrite;
	logic m_textg;
	logic m_mixg;
	logic [7:0] m_newvideo;
	logic [7:0] m_textcolor;
	logic [3:0] m_border;
	logic [7:0] m_sltromsel;
	logic [7:0] m_shadow;
	logic [7:0] m_cyareg;
	irq_en_t m_en;
	logic m_scan_st;
	logic m_sec_st;
	logic m_vgc_any;
	logic m_vbl_fl;
	logic m_qtr_fl;

	// request sitting in the decode stage, and what it should produce
	logic         p_valid;
	bus_req_t     p_req;
	logic         exp_rd_valid;
	logic [7:0]   exp_rd_data;
	logic         exp_mem_valid;
	mapped_addr_t exp_mem_addr;
	logic         exp_irq;

	iigs_glue #(
		.IO_BANK_MASK_EN(IO_MASK)
	) u_iigs_glue (
		.clk_sys      (clk_sys),
		.cpu_vda      (cpu_vda),
		.req_valid    (req_valid),
		.req          (req),
		.vblank       (vblank),
		.scanline_irq (scanline_irq),
		.vbl_irq      (vbl_irq),
		.onesecond_irq(onesecond_irq),
		.qtrsecond_irq(qtrsecond_irq),
		.rd_valid     (rd_valid),
		.rd_data      (rd_data),
		.mem_valid    (mem_valid),
		.mem_addr     (mem_addr),
		.video        (video),
		.irq          (irq)
	);

	always #4 clk_sys = ~clk_sys;

	function automatic int unsigned urand(input int unsigned n);
		int r;
		r = $random(seed);
		return (r & 32'h7fffffff) % n;
	endfunction

	function automatic logic is_io_access(input bus_req_t r);
		logic bank_hit;
		bank_hit = (r.bank == BANK_00) || (r.bank == BANK_E0)
			|| (IO_MASK && ((r.bank == BANK_01) || (r.bank == BANK_E1)));
		return bank_hit && (r.addr[15:8] == IO_PAGE);
	endfunction

	function automatic bus_req_t io_req(input logic [7:0] off, input logic rw,
		input logic [7:0] wd);
		bus_req_t r;
		int unsigned k;
		k = urand(8);
		r.bank  = (k < 3) ? BANK_00 : (k < 6) ? BANK_E0 : (k == 6) ? BANK_01 : BANK_E1;
		r.addr  = {IO_PAGE, off};
		r.rw    = rw;
		r.wdata = wd;
		return r;
	endfunction

	function automatic bus_req_t mem_req(input logic [15:0] addr, input logic rw,
		input logic [7:0] wd);
		bus_req_t r;
		int unsigned k;
		k = urand(10);
		r.bank  = (k < 4) ? BANK_00 : (k < 8) ? BANK_E0 : (k == 8) ? BANK_01 : 8'(urand(256));
		r.addr  = addr;
		r.rw    = rw;
		r.wdata = wd;
		return r;
	endfunction

	task automatic reset_model();
		m_sw        = '0;
		m_intcxrom  = 1'b0;
		m_slotc3    = 1'b0;
		m_col80     = 1'b0;
		m_altchar   = 1'b0;
		m_lc_we     = 1'b0;
		m_prewrite  = 1'b0;
		m_textg     = 1'b0;
		m_mixg      = 1'b0;
		m_newvideo  = NEWVIDEO_RST;
		m_textcolor = TEXTCOLOR_RST;
		m_border    = 4'h0;
		m_sltromsel = 8'h00;
		m_shadow    = SHADOW_RST;
		m_cyareg    = CYAREG_RST;
		m_en        = '0;
		m_scan_st   = 1'b0;
		m_sec_st    = 1'b0;
		m_vgc_any   = 1'b0;
		m_vbl_fl    = 1'b0;
		m_qtr_fl    = 1'b0;
		p_valid       = 1'b0;
		p_req         = '0;
		exp_rd_valid  = 1'b0;
		exp_rd_data   = 8'h00;
		exp_mem_valid = 1'b0;
		exp_mem_addr  = '0;
		exp_irq       = 1'b0;
	endtask

	function automatic logic [7:0] predict_read(input logic [7:0] off, input logic vb);
		logic [15:0] status; // bit n is the flag at c01n
		status = {m_col80, m_altchar, !m_sw.hires, m_sw.page2, m_mixg, m_textg, !vb,
			m_sw.store80, m_slotc3, m_sw.altzp, m_intcxrom, m_sw.ramwrt, m_sw.ramrd,
			m_sw.rdrom, m_sw.lcram2, 1'b0};
		if (off[7:4] == 4'h1)
			return {status[off[3:0]], 7'h00};
		case (off)
			TEXTCOLOR: return m_textcolor;
			VGCINT:    return {m_vgc_any, m_sec_st, m_scan_st, 2'b00, m_en.sec_en,
				m_en.scan_en, 1'b0};
			NEWVIDEO:  return m_newvideo;
			SLTROMSEL: return m_sltromsel;
			CLOCKCTL:  return {4'h0, m_border};
			SHADOW:    return m_shadow;
			CYAREG:    return m_cyareg;
			INTEN:     return {3'b000, m_en.qtr_en, m_en.vbl_en, 3'b000};
			INTFLAG:   return {3'b000, m_qtr_fl, m_vbl_fl, 3'b000};
			STATEREG:  return {m_sw.altzp, m_sw.page2, m_sw.ramrd, m_sw.ramwrt, m_sw.rdrom,
				m_sw.lcram2, m_lc_we, m_intcxrom};
			default:   return 8'h00;
		endcase
	endfunction

	function automatic mapped_addr_t predict_remap(input bus_req_t r);
		mapped_addr_t m;
		logic [7:0] pg;
		logic in_main;
		logic aux;
		pg      = r.addr[15:8];
		in_main = (r.bank == BANK_00) || (r.bank == BANK_E0);
		if (pg < 8'h02 || pg >= 8'hC0)
			aux = m_sw.altzp;
		else if (pg >= 8'h04 && pg <= 8'h07 && m_sw.store80)
			aux = m_sw.page2;
		else if (pg >= 8'h20 && pg <= 8'h3F && m_sw.store80 && m_sw.hires)
			aux = m_sw.page2;
		else
			aux = r.rw ? m_sw.ramrd : m_sw.ramwrt;
		m.addr = r.addr;
		if (in_main && r.addr >= LC_BASE && r.addr <= LC_TOP && m_sw.lcram2 && !m_sw.rdrom)
			m.addr = r.addr - LC_SHIFT; // bank 2 of the language card
		m.bank = (in_main && aux) ? r.bank + 8'h01 : r.bank;
		return m;
	endfunction

	task automatic apply_io_effects(input logic [7:0] off, input logic rd, input logic [7:0] wd);
		if (!rd) begin
			case (off)
				8'h00, 8'h01: m_sw.store80 = off[0];
				8'h06, 8'h07: m_intcxrom = off[0];
				8'h08, 8'h09: m_sw.altzp = off[0];
				8'h0A, 8'h0B: m_slotc3 = off[0];
				8'h0C, 8'h0D: m_col80 = off[0];
				8'h0E, 8'h0F: m_altchar = off[0];
				TEXTCOLOR: m_textcolor = wd;
				NEWVIDEO:  m_newvideo = wd;
				SLTROMSEL: m_sltromsel = wd;
				CLOCKCTL:  m_border = wd[3:0];
				SHADOW:    m_shadow = wd;
				CYAREG:    m_cyareg = wd;
				STATEREG:  {m_sw.altzp, m_sw.page2, m_sw.ramrd, m_sw.ramwrt, m_sw.rdrom,
					m_sw.lcram2, m_lc_we, m_intcxrom} = wd;
				VGCINT: begin
					m_en.sec_en  = wd[2];
					m_en.scan_en = wd[1];
				end
				INTEN: begin
					m_en.qtr_en = wd[4];
					m_en.vbl_en = wd[3];
				end
				VGCINT_CLR: begin
					if (!wd[5])
						m_scan_st = 1'b0;
					if (!wd[6])
						m_sec_st = 1'b0;
					// bit 7 drops once both status bits are clear
					if (!m_scan_st && !m_sec_st)
						m_vgc_any = 1'b0;
				end
				CLRVBL: begin
					m_vbl_fl = 1'b0;
					m_qtr_fl = 1'b0;
				end
				default: ;
			endcase
		end
		// read or write both flip these
		if (off[7:1] == 7'h01)
			m_sw.ramrd = off[0];
		if (off[7:1] == 7'h02)
			m_sw.ramwrt = off[0];
		if (off[7:3] == 5'b01010) begin
			case (off[2:1])
				2'd0: m_textg = off[0];
				2'd1: m_mixg = off[0];
				2'd2: m_sw.page2 = off[0];
				default: m_sw.hires = off[0];
			endcase
		end
		if (off[7:4] == 4'h8) begin
			m_sw.lcram2 = !off[3];
			m_sw.rdrom  = off[0] ^ off[1];
			if (rd && off[0]) begin
				m_lc_we    = m_prewrite; // needs two odd reads in a row
				m_prewrite = 1'b1;
			end else begin
				m_lc_we    = 1'b0;
				m_prewrite = 1'b0;
			end
		end
	endtask

	task automatic check_outputs();
		video_state_t ev;
		ev.textg       = m_textg;
		ev.mixg        = m_mixg;
		ev.page2       = m_sw.page2;
		ev.hires       = m_sw.hires;
		ev.newvideo    = m_newvideo;
		ev.textcolor   = m_textcolor;
		ev.bordercolor = m_border;
		n_checks = n_checks + 4;
		assert (rd_valid === exp_rd_valid) else begin
			$display("ERROR rd_valid: got %h, expected %h", rd_valid, exp_rd_valid);
			n_errors++;
		end
		assert (mem_valid === exp_mem_valid) else begin
			$display("ERROR mem_valid: got %h, expected %h", mem_valid, exp_mem_valid);
			n_errors++;
		end
		assert (irq === exp_irq) else begin
			$display("ERROR irq: got %h, expected %h", irq, exp_irq);
			n_errors++;
		end
		assert (video === ev) else begin
			$display("ERROR video: got %h, expected %h", video, ev);
			n_errors++;
		end
		if (exp_rd_valid) begin
			n_checks++;
			assert (rd_data === exp_rd_data) else begin
				$display("ERROR rd_data: got %h, expected %h", rd_data, exp_rd_data);
				n_errors++;
			end
		end
		if (exp_mem_valid) begin
			n_checks++;
			assert (mem_addr === exp_mem_addr) else begin
				$display("ERROR mem_addr: got %h, expected %h", mem_addr, exp_mem_addr);
				n_errors++;
			end
		end
	endtask

	// one clock: check last results, drive the next request, advance the model
	task automatic run_cycle(input logic v, input bus_req_t r, input logic [3:0] ev,
		input logic vb);
		irq_en_t old_en;
		logic next_irq;
		@(negedge clk_sys);
		check_outputs();
		req_valid = v;
		req       = r;
		vblank    = vb;
		{scanline_irq, vbl_irq, onesecond_irq, qtrsecond_irq} = ev;
		old_en   = m_en;
		next_irq = (m_scan_st && m_en.scan_en) || (m_sec_st && m_en.sec_en)
			|| (m_vbl_fl && m_en.vbl_en) || (m_qtr_fl && m_en.qtr_en);
		exp_rd_valid  = 1'b0;
		exp_mem_valid = 1'b0;
		if (p_valid && is_io_access(p_req)) begin
			if (p_req.rw) begin
				exp_rd_valid = 1'b1;
				exp_rd_data  = predict_read(p_req.addr[7:0], vb);
			end
			apply_io_effects(p_req.addr[7:0], p_req.rw, p_req.wdata);
		end else if (p_valid) begin
			exp_mem_valid = 1'b1;
			exp_mem_addr  = predict_remap(p_req);
		end
		// events land after the clears
		if (ev[3]) begin
			m_scan_st = 1'b1;
			if (old_en.scan_en)
				m_vgc_any = 1'b1;
		end
		if (ev[1] && old_en.sec_en) begin
			m_sec_st  = 1'b1;
			m_vgc_any = 1'b1;
		end
		if (ev[2] && old_en.vbl_en)
			m_vbl_fl = 1'b1;
		if (ev[0] && old_en.qtr_en)
			m_qtr_fl = 1'b1;
		exp_irq = next_irq;
		p_valid = v;
		p_req   = r;
	endtask

	task automatic flush(input int n);
		for (int i = 0; i < n; i++)
			run_cycle(1'b0, '0, 4'h0, 1'(urand(2)));
	endtask

	task automatic report_test(input int num, input string name);
		int errs;
		errs = n_errors - e_mark;
		$display("test %0d %s: %0d checks, %0d errors, %s", num, name, n_checks - c_mark,
			errs, (errs == 0) ? "passed" : "failed");
		c_mark = n_checks;
		e_mark = n_errors;
	endtask

	task automatic wait_idle();
		int n;
		n = 0;
		while ((rd_valid || mem_valid || irq) && n < 10) begin
			@(negedge clk_sys);
			n++;
		end
		n_checks++;
		if (rd_valid || mem_valid || irq) begin
			$display("timeout: outputs still active 10 cycles after reset");
			n_errors++;
		end
	endtask

	initial begin : watchdog
		repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
		$display("timeout: simulation ran past %0d cycles", WATCHDOG_CYCLES);
		$display("Test FAILED");
		$finish;
	end

	initial begin
		int k;
		bus_req_t r;
		logic [7:0] pg;
		logic [3:0] ev;
		clk_sys   = 1'b0;
		cpu_vda   = 1'b1;
		req_valid = 1'b0;
		req       = '0;
		vblank    = 1'b0;
		{scanline_irq, vbl_irq, onesecond_irq, qtrsecond_irq} = 4'h0;
		reset_model();
		repeat (2) @(negedge clk_sys);
		cpu_vda = 1'b0;
		wait_idle();

		for (int i = 8'h11; i <= 8'h1F; i++)
			run_cycle(1'b1, io_req(8'(i), 1'b1, 8'h00), 4'h0, 1'(urand(2)));
		run_cycle(1'b1, io_req(SHADOW, 1'b1, 8'h00), 4'h0, 1'b0);
		run_cycle(1'b1, io_req(NEWVIDEO, 1'b1, 8'h00), 4'h0, 1'b0);
		run_cycle(1'b1, io_req(CYAREG, 1'b1, 8'h00), 4'h0, 1'b0);
		run_cycle(1'b1, io_req(TEXTCOLOR, 1'b1, 8'h00), 4'h0, 1'b0);
		flush(2);
		report_test(1, "reset readback");

		for (int i = 0; i < 300; i++) begin
			k = int'(urand(4));
			case (k)
				0: r = io_req(8'(urand(16)), 1'b0, 8'(urand(256)));
				1: r = io_req(8'h50 + 8'(urand(8)), 1'(urand(2)), 8'(urand(256)));
				2: r = io_req(MEGA_REGS[urand(7)], 1'(urand(2)), 8'(urand(256)));
				default: r = io_req(8'h11 + 8'(urand(15)), 1'b1, 8'h00);
			endcase
			run_cycle(1'b1, r, 4'h0, 1'(urand(2)));
		end
		flush(2);
		report_test(2, "soft switches and mega registers");

		for (int i = 0; i < 300; i++) begin
			k = int'(urand(8));
			if (k < 4)
				r = io_req(8'h80 + 8'(urand(16)), urand(4) != 0, 8'(urand(256)));
			else if (k == 4)
				r = io_req(RD_LCBNK2, 1'b1, 8'h00);
			else if (k == 5)
				r = io_req(RD_RDROM, 1'b1, 8'h00);
			else if (k == 6)
				r = io_req(STATEREG, 1'b1, 8'h00);
			else
				r = mem_req(16'hD000 + 16'(urand(4096)), 1'(urand(2)), 8'(urand(256)));
			run_cycle(1'b1, r, 4'h0, 1'(urand(2)));
		end
		flush(2);
		report_test(3, "language card");

		for (int i = 0; i < 400; i++) begin
			if (urand(4) == 0) begin
				k = int'(urand(7));
				case (k)
					0: r = io_req(8'(urand(2)), 1'b0, 8'h00); // 80store
					1: r = io_req(8'h02 + 8'(urand(2)), 1'(urand(2)), 8'h00);
					2: r = io_req(8'h04 + 8'(urand(2)), 1'(urand(2)), 8'h00);
					3: r = io_req(8'h08 + 8'(urand(2)), 1'b0, 8'h00);
					4: r = io_req(8'h54 + 8'(urand(2)), 1'(urand(2)), 8'h00);
					5: r = io_req(8'h56 + 8'(urand(2)), 1'(urand(2)), 8'h00);
					default: r = io_req(8'h80 + 8'(urand(16)), 1'(urand(2)), 8'h00);
				endcase
			end else begin
				k = int'(urand(6));
				case (k)
					0: pg = 8'(urand(2));
					1: pg = 8'h04 + 8'(urand(4));
					2: pg = 8'h20 + 8'(urand(32));
					3: pg = 8'hD0 + 8'(urand(16));
					4: pg = 8'hC1 + 8'(urand(63));
					default: pg = 8'(urand(256));
				endcase
				r = mem_req({pg, 8'(urand(256))}, 1'(urand(2)), 8'(urand(256)));
			end
			run_cycle(1'b1, r, 4'h0, 1'(urand(2)));
		end
		flush(2);
		report_test(4, "aux and language card remap");

		for (int i = 0; i < 400; i++) begin
			ev = {urand(8) == 0, urand(8) == 0, urand(16) == 0, urand(8) == 0};
			k  = int'(urand(6));
			case (k)
				0: r = io_req(VGCINT, 1'b0, 8'(urand(256)));
				1: r = io_req(INTEN, 1'b0, 8'(urand(256)));
				2: r = io_req(VGCINT_CLR, 1'b0, 8'(urand(256)));
				3: r = io_req(CLRVBL, 1'b0, 8'(urand(256)));
				4: r = io_req((urand(2) == 0) ? VGCINT : INTEN, 1'b1, 8'h00);
				default: r = io_req(INTFLAG, 1'b1, 8'h00);
			endcase
			run_cycle(urand(6) != 0, r, ev, 1'(urand(2)));
		end
		flush(2);
		report_test(5, "interrupts");

		$display("total: %0d checks, %0d errors", n_checks, n_errors);
		if (n_errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule
